// ==== capture_pkg.sv ====
package capture_pkg;

	// word and memory geometry
	parameter int DW = 16;		// sample word width
	parameter int AW = 6;		// address width of one bank, 64 words
	parameter int STAT_W = 16;	// width of count and status outputs

	// framer and buffer defaults
	parameter int N_CHAN = 4;	// channels per group
	parameter int AUTO_FLIP = 1;	// release bank on read of last address

	// one signed sample, same word end to end
	typedef logic signed [DW-1:0] sample_t;

	// status word layout
	// msb is the record type, 1 comfort and 0 fault
	parameter int stat_type_bit = STAT_W - 1;
	parameter int stat_wrap_bit = STAT_W - 2;	// writer wrapped before the stop
	// bits below the wrap bit carry the last valid address
	parameter int stat_addr_w = STAT_W - 2;

	// record type encodings
	parameter logic rec_fault = 1'b0;
	parameter logic rec_comfort = 1'b1;

endpackage

// ==== sample_if.sv ====
`timescale 1ns/10ps

interface sample_if;

	capture_pkg::sample_t data;	// valid only with stb
	logic stb;			// one channel sample
	logic boundary;			// idle cycle between groups
	logic stop;			// single cycle, rides on a boundary

	// framer side
	modport source (
		output data,
		output stb,
		output boundary,
		output stop
	);

	// buffer side
	modport sink (
		input data,
		input stb,
		input boundary,
		input stop
	);

endinterface

// ==== dpram.sv ====
`timescale 1ns/10ps

module dpram #(
	parameter int DW = capture_pkg::DW,
	parameter int AW = capture_pkg::AW	// per bank, the memory holds two
) (
	input  logic clka,
	input  logic clkb,
	input  logic [AW:0] addra,		// msb picks the bank
	input  logic [AW:0] addrb,
	input  capture_pkg::sample_t dina,
	input  logic wena,
	output capture_pkg::sample_t doutb
);

	logic signed [DW-1:0] mem [2**(AW+1)];	// both banks

	// write port, source clock
	always_ff @(posedge clka) begin
		if (wena) mem[addra] <= dina;
	end

	// read port, one clkb of latency
	always_ff @(posedge clkb) begin
		doutb <= mem[addrb];
	end

endmodule

// ==== sample_framer.sv ====
`timescale 1ns/10ps

module sample_framer #(
	parameter int DW = capture_pkg::DW,
	parameter int N_CHAN = capture_pkg::N_CHAN
) (
	input  logic iclk,
	input  logic rst,
	input  capture_pkg::sample_t sample,
	input  logic sample_valid,
	input  logic fault,
	input  logic [7:0] post_count,	// complete groups kept after a fault
	sample_if.source src
);

	localparam int CW = (N_CHAN > 1) ? $clog2(N_CHAN) : 1;

	logic signed [DW-1:0] data_r;	// payload, no reset
	logic stb_r, bnd_r, stop_r;
	logic [CW-1:0] chan;		// channel within the group
	logic last_chan;
	logic bnd_pend;			// group just ended, boundary goes out next
	logic armed;			// fault seen, counting groups
	logic skip;			// group in flight at the fault does not count
	logic [7:0] grp_cnt;
	logic fire;

	assign last_chan = (chan == CW'(N_CHAN - 1));
	// last counted group ends on this boundary
	assign fire = armed & ~skip & bnd_pend & (grp_cnt <= 8'd1);

	always_ff @(posedge iclk) begin
		data_r <= sample;
	end

	always_ff @(posedge iclk) begin
		if (rst) begin
			stb_r <= 1'b0;
			bnd_r <= 1'b0;
			stop_r <= 1'b0;
			chan <= '0;
			bnd_pend <= 1'b0;
			armed <= 1'b0;
			skip <= 1'b0;
			grp_cnt <= '0;
		end else begin
			stb_r <= sample_valid;			// one cycle behind the input
			bnd_pend <= sample_valid & last_chan;
			bnd_r <= bnd_pend;			// boundary one cycle after n-th stb
			stop_r <= fire;				// lands with bnd_r
			if (sample_valid) chan <= last_chan ? '0 : chan + 1'b1;
			if (armed) begin
				// faults while armed are ignored
				if (bnd_pend) begin
					if (skip) skip <= 1'b0;		// partial group, not counted
					else if (grp_cnt <= 8'd1) armed <= 1'b0;
					else grp_cnt <= grp_cnt - 8'd1;
				end
			end else if (fault) begin
				armed <= 1'b1;
				grp_cnt <= post_count;
				skip <= (chan != '0) | sample_valid;	// fault landed mid group
			end
		end
	end

	assign src.data = data_r;
	assign src.stb = stb_r;
	assign src.boundary = bnd_r;
	assign src.stop = stop_r;

endmodule

// ==== circle_buf.sv ====
`timescale 1ns/10ps

module circle_buf #(
	parameter int DW = capture_pkg::DW,
	parameter int AW = capture_pkg::AW,
	parameter int STAT_W = capture_pkg::STAT_W,
	parameter int AUTO_FLIP = capture_pkg::AUTO_FLIP
) (
	input  logic iclk,
	input  logic oclk,
	input  logic rst,
	sample_if.sink snk,
	output logic enable,			// reader may walk its bank
	input  logic [AW-1:0] read_addr,
	output capture_pkg::sample_t d_out,
	input  logic stb_out,			// read of read_addr is done
	output logic buf_sync,
	output logic buf_transferred,
	output logic [STAT_W-1:0] buf_count,	// banks handed over
	output logic [STAT_W-1:0] buf_stat,
	output logic [AW-1:0] buf_stat2		// last valid address of the record
);

	import capture_pkg::*;

	logic [AW-1:0] write_addr;
	logic [AW-1:0] save_addr;	// write position frozen at the stop
	logic [AW-1:0] save_addr0;	// published with the bank
	logic wbank;			// bank being written
	logic rbank_x;			// rbank seen in iclk
	logic run;			// 0 once a stop froze the record
	logic pend;			// stop waiting for its boundary
	logic boundary_ok;		// writes resume only on a group boundary
	logic record_type;
	logic buff_wrap, stat_wrap;
	logic [1:0] wrapped;		// per bank, overwritten without a flip
	logic change_req, end_write_addr, at_end, flip, stop_write, write_en;
	logic [stat_addr_w-1:0] addr_ext;

	logic rbank;			// inverse of the bank being read
	logic wbank_x;			// wbank seen in oclk
	logic flip_read;

	// flags differ once the reader has let go of its bank
	assign change_req = wbank ^ rbank_x;
	assign end_write_addr = &write_addr;
	assign at_end = snk.stb & boundary_ok & end_write_addr;
	assign flip = at_end & change_req;
	assign stop_write = (snk.stop | pend) & snk.boundary & run;
	assign write_en = snk.stb & boundary_ok & run;

	always_ff @(posedge iclk) begin
		if (rst) begin
			write_addr <= '0;
			save_addr <= '0;
			save_addr0 <= '0;
			wbank <= 1'b0;
			rbank_x <= 1'b1;		// matches rbank reset, first flip allowed
			run <= 1'b1;
			pend <= 1'b0;
			boundary_ok <= 1'b1;
			record_type <= rec_comfort;
			buff_wrap <= 1'b0;
			stat_wrap <= 1'b0;
			wrapped <= '0;
			buf_count <= '0;
			buf_transferred <= 1'b0;
		end else begin
			rbank_x <= rbank;		// clock crossing, single flop
			buf_transferred <= flip;
			if (snk.boundary | (snk.stb & end_write_addr)) boundary_ok <= snk.boundary;
			if (snk.stb & boundary_ok) write_addr <= write_addr + 1'b1;	// circular
			if (at_end) begin
				if (change_req) wrapped[~wbank] <= 1'b0;	// next bank starts clean
				else wrapped[wbank] <= 1'b1;			// reader still busy
			end
			// a stop off its boundary waits for the next one
			if (snk.stop | snk.boundary) pend <= snk.stop & ~snk.boundary & run;
			if (stop_write) begin
				run <= 1'b0;
				save_addr <= write_addr;
				buff_wrap <= wrapped[wbank];
			end
			if (flip) begin
				run <= 1'b1;
				wbank <= ~wbank;
				record_type <= run;		// fault 0, comfort 1
				save_addr0 <= run ? '0 : save_addr;
				stat_wrap <= ~run & buff_wrap;
				buf_count <= buf_count + 1'b1;
			end
		end
	end

	assign buf_sync = flip;
	assign buf_stat2 = save_addr0;
	assign addr_ext = stat_addr_w'(save_addr0);	// truncate or zero pad

	always_comb begin
		buf_stat = '0;
		buf_stat[stat_type_bit] = record_type;
		buf_stat[stat_wrap_bit] = stat_wrap;
		buf_stat[stat_addr_w-1:0] = addr_ext;
	end

	// reader owns bank ~rbank, enabled while the writer is elsewhere
	assign enable = ~(wbank_x ^ rbank);
	assign flip_read = stb_out & enable & ((&read_addr) | (AUTO_FLIP == 0));

	always_ff @(posedge oclk) begin
		if (rst) begin
			rbank <= 1'b1;		// reader waits on bank 0 until it fills
			wbank_x <= 1'b0;
		end else begin
			wbank_x <= wbank;	// clock crossing, single flop
			if (flip_read) rbank <= ~rbank;
		end
	end

	dpram #(
		.DW(DW),
		.AW(AW)
	) u_mem (
		.clka(iclk),
		.clkb(oclk),
		.addra({wbank, write_addr}),
		.addrb({~rbank, read_addr}),
		.dina(snk.data),
		.wena(write_en),
		.doutb(d_out)
	);

endmodule

// ==== readout_engine.sv ====
`timescale 1ns/10ps

module readout_engine #(
	parameter int AW = capture_pkg::AW
) (
	input  logic oclk,
	input  logic rst,
	input  logic enable,
	output logic [AW-1:0] read_addr,
	input  capture_pkg::sample_t d_out,
	output logic stb_out,
	output capture_pkg::sample_t out_data,
	output logic out_req,
	input  logic out_ack
);

	typedef enum logic [2:0] {
		S_IDLE,		// wait for a readable bank
		S_READ,		// address presented to the memory
		S_CAPT,		// word on d_out
		S_REQ,		// req high, wait for ack
		S_DROP,		// req low, wait for ack to fall
		S_STB		// word delivered, release the address
	} state_t;

	state_t state;

	always_ff @(posedge oclk) begin
		if (rst) begin
			state <= S_IDLE;
			read_addr <= '0;
			out_req <= 1'b0;
		end else begin
			case (state)
				S_IDLE: if (enable) state <= S_READ;
				S_READ: state <= S_CAPT;		// one cycle memory latency
				S_CAPT: begin
					if (!out_ack) begin		// never raise req over a high ack
						out_req <= 1'b1;
						state <= S_REQ;
					end
				end
				S_REQ: begin
					if (out_ack) begin
						out_req <= 1'b0;
						state <= S_DROP;
					end
				end
				S_DROP: if (!out_ack) state <= S_STB;
				S_STB: begin
					read_addr <= read_addr + 1'b1;	// wraps to zero after the last
					state <= (&read_addr) ? S_IDLE : S_READ;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// data held from capture until the next word
	always_ff @(posedge oclk) begin
		if (state == S_CAPT && !out_ack) out_data <= d_out;
	end

	assign stb_out = (state == S_STB);	// last address here hands the bank back

endmodule

// ==== capture_top.sv ====
`timescale 1ns/10ps

module capture_top #(
	parameter int DW = capture_pkg::DW,
	parameter int AW = capture_pkg::AW,
	parameter int STAT_W = capture_pkg::STAT_W,
	parameter int N_CHAN = capture_pkg::N_CHAN,
	parameter int AUTO_FLIP = capture_pkg::AUTO_FLIP
) (
	input  logic iclk,
	input  logic oclk,
	input  logic rst,
	input  capture_pkg::sample_t sample,
	input  logic sample_valid,
	input  logic fault,
	input  logic [7:0] post_count,
	output capture_pkg::sample_t out_data,
	output logic out_req,
	input  logic out_ack,
	output logic buf_sync,
	output logic buf_transferred,
	output logic [STAT_W-1:0] buf_count,
	output logic [STAT_W-1:0] buf_stat,
	output logic [AW-1:0] buf_stat2
);

	logic enable;
	logic [AW-1:0] read_addr;
	capture_pkg::sample_t d_out;
	logic stb_out;

	sample_if u_frm ();	// framed stream, iclk

	sample_framer #(
		.DW(DW),
		.N_CHAN(N_CHAN)
	) u_framer (
		.iclk(iclk),
		.rst(rst),
		.sample(sample),
		.sample_valid(sample_valid),
		.fault(fault),
		.post_count(post_count),
		.src(u_frm.source)
	);

	circle_buf #(
		.DW(DW),
		.AW(AW),
		.STAT_W(STAT_W),
		.AUTO_FLIP(AUTO_FLIP)
	) u_buf (
		.iclk(iclk),
		.oclk(oclk),
		.rst(rst),
		.snk(u_frm.sink),
		.enable(enable),
		.read_addr(read_addr),
		.d_out(d_out),
		.stb_out(stb_out),
		.buf_sync(buf_sync),
		.buf_transferred(buf_transferred),
		.buf_count(buf_count),
		.buf_stat(buf_stat),
		.buf_stat2(buf_stat2)
	);

	readout_engine #(
		.AW(AW)
	) u_rd (
		.oclk(oclk),
		.rst(rst),
		.enable(enable),
		.read_addr(read_addr),
		.d_out(d_out),
		.stb_out(stb_out),
		.out_data(out_data),
		.out_req(out_req),
		.out_ack(out_ack)
	);

endmodule

// ==== capture_chk.sv ====
`timescale 1ns/10ps

module capture_chk #(
	parameter int STAT_W = capture_pkg::STAT_W
) (
	input  logic iclk,
	input  logic oclk,
	input  logic rst,
	input  logic buf_sync,
	input  logic buf_transferred,
	input  logic [STAT_W-1:0] buf_count,
	input  logic out_req,
	input  logic out_ack,
	input  capture_pkg::sample_t out_data
);

	int fails = 0;	// assertion failures so far

	// outputs quiet out of reset
	reset_quiet: assert property (@(posedge iclk)
		rst |=> !buf_sync && !buf_transferred && buf_count == '0)
		else begin
			$error("buffer outputs active in reset");
			fails++;
		end
	reset_req: assert property (@(posedge oclk) rst |=> !out_req)
		else begin
			$error("out_req high in reset");
			fails++;
		end

	// flip taken one cycle after the sync pulse, and only then
	xfer_follows: assert property (@(posedge iclk) disable iff (rst)
		buf_sync |=> buf_transferred)
		else begin
			$error("buf_transferred missing after buf_sync");
			fails++;
		end
	xfer_only: assert property (@(posedge iclk) disable iff (rst)
		buf_transferred |-> $past(buf_sync))
		else begin
			$error("buf_transferred without buf_sync");
			fails++;
		end

	// bank counter steps with buf_sync only
	count_step: assert property (@(posedge iclk) disable iff (rst)
		$past(buf_sync) |-> buf_count == $past(buf_count) + 1'b1)
		else begin
			$error("buf_count did not step on buf_sync");
			fails++;
		end
	count_hold: assert property (@(posedge iclk) disable iff (rst)
		!$past(buf_sync) |-> buf_count == $past(buf_count))
		else begin
			$error("buf_count moved without buf_sync");
			fails++;
		end

	// four-phase rules on the host side
	req_fall: assert property (@(posedge oclk) disable iff (rst)
		$fell(out_req) |-> $past(out_ack))
		else begin
			$error("out_req dropped before out_ack");
			fails++;
		end
	req_rise: assert property (@(posedge oclk) disable iff (rst)
		$rose(out_req) |-> !$past(out_ack))
		else begin
			$error("out_req raised over a high out_ack");
			fails++;
		end
	data_hold: assert property (@(posedge oclk) disable iff (rst)
		out_req && $past(out_req) |-> $stable(out_data))
		else begin
			$error("out_data changed while out_req high");
			fails++;
		end

endmodule

// top ports carry both the buffer and the readout signals
bind capture_top capture_chk #(
	.STAT_W(STAT_W)
) u_chk (
	.iclk(iclk),
	.oclk(oclk),
	.rst(rst),
	.buf_sync(buf_sync),
	.buf_transferred(buf_transferred),
	.buf_count(buf_count),
	.out_req(out_req),
	.out_ack(out_ack),
	.out_data(out_data)
);

// ==== tb_capture.sv ====
`timescale 1ns/10ps

module tb_capture;

	import capture_pkg::*;

	parameter int unsigned SEED = 32'h4590d96e;
	localparam int BANK = 2**AW;
	localparam int LIMIT = 20 * BANK * (N_CHAN + 1) * 8;	// cycles before giving up

	logic iclk = 1'b0;
	logic oclk = 1'b0;
	logic rst;
	sample_t sample;
	logic sample_valid, fault;
	logic [7:0] post_count;
	sample_t out_data;
	logic out_req;
	logic out_ack = 1'b0;
	logic buf_sync, buf_transferred;
	logic [STAT_W-1:0] buf_count, buf_stat;
	logic [AW-1:0] buf_stat2;

	sample_t ramp;			// next sample value
	sample_t prev_word;
	int n_flip = 0, n_word = 0, ack_wait = 0, cycles = 0;
	int err_comfort = 0, n_run = 0, n_fail = 0, errs;
	logic data_chk = 1'b0, type_chk = 1'b0, long_mode = 1'b0;
	logic fault_seen = 1'b0;
	logic [STAT_W-1:0] rec_stat;	// status of the fault record
	logic [AW-1:0] rec_stat2;

	capture_top u_dut (.*);

	initial forever #50 iclk = ~iclk;
	initial forever #65 oclk = ~oclk;

	// host acks after a random number of oclk cycles
	always @(posedge oclk) begin
		if (rst) begin
			out_ack <= 1'b0;
		end else if (out_req && !out_ack) begin
			if (ack_wait > 0) ack_wait <= ack_wait - 1;
			else begin
				out_ack <= 1'b1;
				if (data_chk && (n_word % BANK) != 0
					&& out_data !== sample_t'(prev_word + 1)) begin
					$display("Error: comfort expected %0h actual %0h",
						sample_t'(prev_word + 1), out_data);
					err_comfort++;
				end
				prev_word = out_data;
				n_word++;		// bank start is every BANK words
			end
		end else if (!out_req && out_ack) begin
			out_ack <= 1'b0;
			ack_wait <= long_mode ? 16 + int'($urandom % 16) : int'($urandom % 4);
		end
	end

	// status is settled once buf_transferred shows
	always @(posedge iclk) begin
		if (!rst && buf_transferred) begin
			n_flip++;
			if (type_chk && !buf_stat[stat_type_bit]) begin
				$display("Error: comfort expected 1 actual 0");
				err_comfort++;
			end
			if (!buf_stat[stat_type_bit] && !fault_seen) begin
				fault_seen = 1'b1;
				rec_stat = buf_stat;
				rec_stat2 = buf_stat2;
			end
		end
	end

	always @(posedge iclk) begin
		cycles++;
		if (cycles >= LIMIT) begin
			$display("timeout: the run did not finish within %0d cycles", LIMIT);
			$display("** FAIL **");
			$finish;
		end
	end

	// one group of ramp samples and the idle cycle the framer needs
	task automatic send_group();
		repeat (N_CHAN) begin
			@(posedge iclk);
			fault <= 1'b0;
			sample <= ramp;
			sample_valid <= 1'b1;
			ramp = ramp + 1'b1;
		end
		@(posedge iclk);
		sample_valid <= 1'b0;
	endtask

	task automatic check_val(input string name, input int exp, input int act, inout int e);
		if (exp != act) begin
			$display("Error: %s expected %0h actual %0h", name, exp, act);
			e++;
		end
	endtask

	task automatic report(input string name, input int e);
		n_run++;
		if (e != 0) n_fail++;
		$display("test %-10s %s (%0d errors)", name, (e == 0) ? "ok" : "failed", e);
	endtask

	// fault between groups so the stop lands after post_count more groups
	task automatic run_fault(input string name, input logic exp_wrap, output int e);
		logic [AW-1:0] exp_addr;
		e = 0;
		fault_seen = 1'b0;
		exp_addr = ramp[AW-1:0] + AW'(3 * N_CHAN);	// ramp value maps to its address
		@(posedge iclk);
		fault <= 1'b1;
		while (!fault_seen) send_group();
		check_val(name, 0, rec_stat[stat_type_bit], e);
		check_val(name, exp_addr, rec_stat2, e);
		check_val(name, exp_addr, rec_stat[stat_addr_w-1:0], e);
		check_val(name, int'(exp_wrap), rec_stat[stat_wrap_bit], e);
	endtask

	initial begin
		void'($urandom(SEED));
		rst = 1'b1;
		sample = '0;
		sample_valid = 1'b0;
		fault = 1'b0;
		post_count = 8'd3;
		ramp = '0;
		repeat (10) @(posedge iclk);
		rst <= 1'b0;

		// comfort records with a continuous ramp per bank
		data_chk = 1'b1;
		type_chk = 1'b1;
		while (n_flip < 3) send_group();
		repeat (2) @(posedge iclk);
		if (n_word < BANK) begin
			$display("comfort: reader delivered only %0d words", n_word);
			err_comfort++;
		end
		data_chk = 1'b0;
		type_chk = 1'b0;
		report("comfort", err_comfort);
		errs = 0;
		check_val("count", n_flip, int'(buf_count), errs);
		report("count", errs);

		run_fault("fault", 1'b0, errs);
		report("fault", errs);

		// slow host keeps the reader on its bank and the writer laps its own
		long_mode = 1'b1;
		repeat (BANK / N_CHAN + 1) send_group();
		run_fault("wrap", 1'b1, errs);
		report("wrap", errs);

		report("assertions", u_dut.u_chk.fails);
		$display("tests run %0d, failed %0d", n_run, n_fail);
		if (n_fail == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

// ==== tb.f ====
capture_pkg.sv
sample_if.sv
dpram.sv
sample_framer.sv
circle_buf.sv
readout_engine.sv
capture_top.sv
capture_chk.sv
tb_capture.sv

// ==== Makefile ====
TOP ?= tb_capture
SEED ?= 32'h4590d96e
LOG ?= sim.log
VERILATOR ?= verilator
OBJ ?= obj_dir

.PHONY: all build run clean

all: run

build:
	$(VERILATOR) --binary --timing --assert -Wno-fatal -f tb.f \
		--top-module $(TOP) -GSEED=$(SEED) --Mdir $(OBJ)

run: build
	./$(OBJ)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "\*\* FAIL \*\*" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "\*\* PASS \*\*" $(LOG); then echo "no result in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ) $(LOG)
